/* mem_subsys_top.f */
+incdir+include
design/bus_pkg.sv
design/arb_pkg.sv
design/req_hold_reg.sv
design/bus_owner_fsm.sv
design/wait_timer.sv
design/sram_slave.sv
design/bus_bridge.sv
design/bus_duplexer.sv
design/mem_subsys_top.sv
test/tb_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f mem_subsys_top.f --top-module tb_mem_subsys -o tb_mem_subsys

# keep going on a failing run so the log can be searched
./obj_dir/tb_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

/* test/tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "bus_defines.svh"

module tb_mem_subsys;
    localparam int LAT = `MEM_WAIT + 3;
    localparam int N_RAND = 200;
    localparam int N_OPS = `MEM_WORDS + 40 + N_RAND;
    localparam longint LIMIT_NS = longint'(N_OPS) * 2 * LAT * 8 + 4000;
    localparam int IDX_W = $clog2(`MEM_WORDS);

    typedef struct packed {
        bus_pkg::bus_rsp_t rsp;
        logic              solo; // other port idle at issue
        logic [31:0]       cyc;
    } exp_t;

    logic               clk = 1'b0;
    logic               rstn = 1'b0;
    logic               i_insn_req = 1'b0;
    bus_pkg::insn_req_t i_insn_info = '0;
    logic               o_insn_resp;
    bus_pkg::bus_rsp_t  o_insn_rsp;
    logic               i_data_req = 1'b0;
    bus_pkg::data_req_t i_data_info = '0;
    logic               o_data_resp;
    bus_pkg::bus_rsp_t  o_data_rsp;

    exp_t        insn_q[$];
    exp_t        data_q[$];
    exp_t        ins_exp = '0;
    exp_t        dat_exp = '0;
    logic        ins_ok = 1'b0;
    logic        dat_ok = 1'b0;
    logic [31:0] ins_lat = '0;
    logic [31:0] dat_lat = '0;
    logic [31:0] cyc = '0;
    logic [31:0] shadow [`MEM_WORDS];
    logic [31:0] rng = 32'd22;
    int          n_req_i = 0;
    int          n_req_d = 0;
    int          n_rsp_i = 0;
    int          n_rsp_d = 0;

    always #4 clk = ~clk;

    mem_subsys_top dut (.*);

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // reference model of one access that also updates the shadow memory
    function automatic bus_pkg::bus_rsp_t model_access(input bus_pkg::data_req_t r);
        bus_pkg::bus_rsp_t rsp;
        int                nbytes;
        int                lane;
        logic [IDX_W-1:0]  word;
        nbytes = (r.acc == bus_pkg::ACC_BYTE) ? 1 : (r.acc == bus_pkg::ACC_HALF) ? 2 : 4;
        lane   = int'(r.addr[1:0]);
        word   = r.addr[IDX_W+1:2];
        rsp    = '0;
        if (r.addr % nbytes != 0 || r.addr / 4 >= `MEM_WORDS) begin
            rsp.fault = 1'b1;
        end else begin
            for (int b = 0; b < nbytes; b++) begin
                if (r.w_rb)
                    shadow[word][8*(lane+b) +: 8] = r.wdata[8*b +: 8];
                else
                    rsp.rdata[8*b +: 8] = shadow[word][8*(lane+b) +: 8];
            end
        end
        return rsp;
    endfunction

    // called right after a posedge
    task automatic put_inputs(input logic do_i, input bus_pkg::insn_req_t ir,
                              input logic do_d, input bus_pkg::data_req_t dr);
        exp_t e;
        i_insn_req <= do_i;
        i_data_req <= do_d;
        if (do_d) begin
            i_data_info <= dr;
            e.rsp  = model_access(dr); // data wins a tie and is modelled first
            e.solo = !do_i && insn_q.size() == 0;
            e.cyc  = cyc;
            data_q.push_back(e);
            n_req_d++;
        end
        if (do_i) begin
            i_insn_info <= ir;
            e.rsp  = model_access(bus_pkg::data_req_t'{addr: ir.addr, w_rb: 1'b0,
                                                      acc: ir.acc, wdata: 32'h0});
            e.solo = !do_d && data_q.size() == 0;
            e.cyc  = cyc;
            insn_q.push_back(e);
            n_req_i++;
        end
    endtask

    task automatic idle_until_done();
        while (insn_q.size() != 0 || data_q.size() != 0) begin
            @(posedge clk);
            put_inputs(1'b0, '0, 1'b0, '0);
        end
    endtask

    task automatic data_op(input logic [31:0] a, input logic w, input bus_pkg::acc_e acc,
                           input logic [31:0] wd);
        @(posedge clk);
        put_inputs(1'b0, '0, 1'b1, bus_pkg::data_req_t'{addr: a, w_rb: w, acc: acc, wdata: wd});
        idle_until_done();
    endtask

    task automatic insn_op(input logic [31:0] a, input bus_pkg::acc_e acc);
        @(posedge clk);
        put_inputs(1'b1, bus_pkg::insn_req_t'{addr: a, acc: acc}, 1'b0, '0);
        idle_until_done();
    endtask

    function automatic bus_pkg::acc_e rand_acc();
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'd0: return bus_pkg::ACC_BYTE;
            2'd1: return bus_pkg::ACC_HALF;
            default: return bus_pkg::ACC_WORD;
        endcase
    endfunction

    function automatic logic [31:0] rand_addr(input bus_pkg::acc_e acc);
        logic [31:0] r;
        logic [31:0] a;
        r = next_rand();
        a = {22'b0, r[9:0]};
        if (r[31:28] == 4'd0)
            return 32'(`MEM_WORDS * 4) + a; // past the end
        if (r[27:26] != 2'd0 && acc == bus_pkg::ACC_HALF)
            a[0] = 1'b0;
        if (r[27:26] != 2'd0 && acc == bus_pkg::ACC_WORD)
            a[1:0] = 2'b00;
        return a;
    endfunction

    task automatic random_phase();
        int                 left;
        logic               do_i;
        logic               do_d;
        logic [31:0]        r;
        bus_pkg::insn_req_t ir;
        bus_pkg::data_req_t dr;
        left = N_RAND;
        while (left > 0) begin
            @(posedge clk);
            r        = next_rand();
            do_d     = data_q.size() == 0 && r[1:0] != 2'd0;
            do_i     = insn_q.size() == 0 && r[3:2] != 2'd0 && !(do_d && left == 1);
            dr.acc   = rand_acc();
            dr.addr  = rand_addr(dr.acc);
            dr.w_rb  = r[4];
            dr.wdata = next_rand();
            ir.acc   = rand_acc();
            ir.addr  = rand_addr(ir.acc);
            put_inputs(do_i, ir, do_d, dr);
            left = left - int'(do_i) - int'(do_d);
        end
    endtask

    // outputs are settled here and the popped head holds until next posedge
    always @(negedge clk) begin
        if (o_insn_resp === 1'b1) begin
            ins_ok = insn_q.size() != 0;
            if (ins_ok) begin
                ins_exp = insn_q.pop_front();
                ins_lat = cyc - ins_exp.cyc;
            end
            n_rsp_i++;
        end
        if (o_data_resp === 1'b1) begin
            dat_ok = data_q.size() != 0;
            if (dat_ok) begin
                dat_exp = data_q.pop_front();
                dat_lat = cyc - dat_exp.cyc;
            end
            n_rsp_d++;
        end
        cyc = cyc + 1;
    end

    a_reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> !o_insn_resp && !o_data_resp)
        else fail_run("a response strobe was high right after reset");

    a_insn_has_req: assert property (@(posedge clk) disable iff (!rstn) o_insn_resp |-> ins_ok)
        else fail_run("instruction port gave a response with no request outstanding");
    a_data_has_req: assert property (@(posedge clk) disable iff (!rstn) o_data_resp |-> dat_ok)
        else fail_run("data port gave a response with no request outstanding");

    a_insn_value: assert property (@(posedge clk) disable iff (!rstn)
        o_insn_resp && ins_ok |-> o_insn_rsp == ins_exp.rsp)
        else fail_run($sformatf("mismatch at %0t: insn rdata %h fault %b, expected %h %b",
            $time, $sampled(o_insn_rsp.rdata), $sampled(o_insn_rsp.fault),
            ins_exp.rsp.rdata, ins_exp.rsp.fault));
    a_data_value: assert property (@(posedge clk) disable iff (!rstn)
        o_data_resp && dat_ok |-> o_data_rsp == dat_exp.rsp)
        else fail_run($sformatf("mismatch at %0t: data rdata %h fault %b, expected %h %b",
            $time, $sampled(o_data_rsp.rdata), $sampled(o_data_rsp.fault),
            dat_exp.rsp.rdata, dat_exp.rsp.fault));

    a_insn_latency: assert property (@(posedge clk) disable iff (!rstn)
        o_insn_resp && ins_ok && ins_exp.solo |-> ins_lat == LAT)
        else fail_run($sformatf("mismatch at %0t: insn resp after %0d cycles, expected %0d",
            $time, ins_lat, LAT));
    a_data_latency: assert property (@(posedge clk) disable iff (!rstn)
        o_data_resp && dat_ok && dat_exp.solo |-> dat_lat == LAT)
        else fail_run($sformatf("mismatch at %0t: data resp after %0d cycles, expected %0d",
            $time, dat_lat, LAT));

    initial begin
        #(LIMIT_NS);
        fail_run("watchdog expired, the run hung waiting for responses");
    end

    initial begin
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < `MEM_WORDS; i++)
            data_op(32'(i * 4), 1'b1, bus_pkg::ACC_WORD, 32'(i) * 32'h9e37_79b1 + 32'h1357_9bdf);
        // sized writes merge into filled words
        data_op(32'h12, 1'b1, bus_pkg::ACC_HALF, 32'hdead_beef);
        data_op(32'h21, 1'b1, bus_pkg::ACC_BYTE, 32'h0000_00a5);
        data_op(32'h23, 1'b1, bus_pkg::ACC_BYTE, 32'hffff_ff3c);
        data_op(32'h44, 1'b1, bus_pkg::ACC_WORD, 32'h0bad_f00d);
        data_op(32'h10, 1'b0, bus_pkg::ACC_WORD, 32'h0);
        data_op(32'h12, 1'b0, bus_pkg::ACC_HALF, 32'h0);
        data_op(32'h10, 1'b0, bus_pkg::ACC_HALF, 32'h0);
        data_op(32'h20, 1'b0, bus_pkg::ACC_WORD, 32'h0);
        data_op(32'h21, 1'b0, bus_pkg::ACC_BYTE, 32'h0);
        data_op(32'h22, 1'b0, bus_pkg::ACC_BYTE, 32'h0);
        data_op(32'h47, 1'b0, bus_pkg::ACC_BYTE, 32'h0);
        insn_op(32'h10, bus_pkg::ACC_WORD);
        insn_op(32'h12, bus_pkg::ACC_HALF);
        insn_op(32'h23, bus_pkg::ACC_BYTE);
        insn_op(32'h44, bus_pkg::ACC_WORD);
        // misaligned and out of range accesses followed by read back
        data_op(32'h31, 1'b1, bus_pkg::ACC_WORD, 32'h1111_1111);
        data_op(32'h33, 1'b1, bus_pkg::ACC_HALF, 32'h2222_2222);
        data_op(32'h400, 1'b1, bus_pkg::ACC_WORD, 32'h3333_3333);
        data_op(32'hffff_fffc, 1'b1, bus_pkg::ACC_WORD, 32'h4444_4444);
        data_op(32'h30, 1'b0, bus_pkg::ACC_WORD, 32'h0);
        data_op(32'h402, 1'b0, bus_pkg::ACC_HALF, 32'h0);
        data_op(32'h3ff, 1'b1, bus_pkg::ACC_BYTE, 32'h0000_0077);
        data_op(32'h3fc, 1'b0, bus_pkg::ACC_WORD, 32'h0);
        insn_op(32'h06, bus_pkg::ACC_WORD);
        insn_op(32'h800, bus_pkg::ACC_WORD);
        insn_op(32'h01, bus_pkg::ACC_HALF);
        @(posedge clk); // both ports in one cycle
        put_inputs(1'b1, bus_pkg::insn_req_t'{addr: 32'h40, acc: bus_pkg::ACC_WORD}, 1'b1,
                   bus_pkg::data_req_t'{addr: 32'h40, w_rb: 1'b1, acc: bus_pkg::ACC_WORD,
                                        wdata: 32'hcafe_0042});
        idle_until_done();
        random_phase();
        idle_until_done();
        repeat (4) @(posedge clk);
        if (n_rsp_i != n_req_i || n_rsp_d != n_req_d) begin
            fail_run("number of responses does not match number of requests");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* design/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic               clk,
    input  logic               rstn,

    input  logic               i_insn_req,
    input  bus_pkg::insn_req_t i_insn_info,
    output logic               o_insn_resp,
    output bus_pkg::bus_rsp_t  o_insn_rsp,

    input  logic               i_data_req,
    input  bus_pkg::data_req_t i_data_info,
    output logic               o_data_resp,
    output bus_pkg::bus_rsp_t  o_data_rsp
);
    logic               dup_req;
    bus_pkg::data_req_t dup_bus_req;
    logic               dup_resp;
    bus_pkg::bus_rsp_t  dup_bus_rsp;
    logic               mem_req;
    bus_pkg::data_req_t mem_bus_req;
    logic               mem_resp;
    bus_pkg::bus_rsp_t  mem_bus_rsp;

    bus_duplexer u_duplexer (
        .clk        (clk),
        .rstn       (rstn),
        .i_insn_req (i_insn_req),
        .i_insn_info(i_insn_info),
        .o_insn_resp(o_insn_resp),
        .o_insn_rsp (o_insn_rsp),
        .i_data_req (i_data_req),
        .i_data_info(i_data_info),
        .o_data_resp(o_data_resp),
        .o_data_rsp (o_data_rsp),
        .o_req      (dup_req),
        .o_bus_req  (dup_bus_req),
        .i_resp     (dup_resp),
        .i_bus_rsp  (dup_bus_rsp)
    );

    bus_bridge u_bridge (
        .clk        (clk),
        .rstn       (rstn),
        .i_d_req    (dup_req),
        .i_d_bus_req(dup_bus_req),
        .o_d_resp   (dup_resp),
        .o_d_bus_rsp(dup_bus_rsp),
        .o_p_req    (mem_req),
        .o_p_bus_req(mem_bus_req),
        .i_p_resp   (mem_resp),
        .i_p_bus_rsp(mem_bus_rsp)
    );

    sram_slave u_sram (
        .clk      (clk),
        .rstn     (rstn),
        .i_req    (mem_req),
        .i_bus_req(mem_bus_req),
        .o_resp   (mem_resp),
        .o_bus_rsp(mem_bus_rsp)
    );

endmodule

/* design/bus_duplexer.sv */
`timescale 1ns/1ps

module bus_duplexer (
    input  logic               clk,
    input  logic               rstn,

    // instruction port
    input  logic               i_insn_req,
    input  bus_pkg::insn_req_t i_insn_info,
    output logic               o_insn_resp,
    output bus_pkg::bus_rsp_t  o_insn_rsp,

    // data port
    input  logic               i_data_req,
    input  bus_pkg::data_req_t i_data_info,
    output logic               o_data_resp,
    output bus_pkg::bus_rsp_t  o_data_rsp,

    // memory bus
    output logic               o_req,
    output bus_pkg::data_req_t o_bus_req,
    input  logic               i_resp,
    input  bus_pkg::bus_rsp_t  i_bus_rsp
);
    bus_pkg::insn_req_t insn_held;
    bus_pkg::data_req_t data_held;
    logic               insn_pending;
    logic               data_pending;
    arb_pkg::owner_e    owner;
    arb_pkg::owner_e    next_owner;

    req_hold_reg #(.payload_t(bus_pkg::insn_req_t)) u_insn_hold (
        .clk      (clk),
        .rstn     (rstn),
        .i_req    (i_insn_req),
        .i_payload(i_insn_info),
        .o_payload(insn_held),
        .i_resp   (o_insn_resp),
        .o_pending(insn_pending)
    );

    req_hold_reg #(.payload_t(bus_pkg::data_req_t)) u_data_hold (
        .clk      (clk),
        .rstn     (rstn),
        .i_req    (i_data_req),
        .i_payload(i_data_info),
        .o_payload(data_held),
        .i_resp   (o_data_resp),
        .o_pending(data_pending)
    );

    bus_owner_fsm u_owner (
        .clk           (clk),
        .rstn          (rstn),
        .i_insn_req    (i_insn_req),
        .i_data_req    (i_data_req),
        .i_insn_pending(insn_pending),
        .i_data_pending(data_pending),
        .i_resp        (i_resp),
        .o_owner       (owner),
        .o_next_owner  (next_owner),
        .o_req         (o_req)
    );

    // payload follows the port about to own the bus
    always_comb begin
        o_bus_req = '0;
        case (next_owner)
            arb_pkg::OWN_INSN: begin
                o_bus_req.addr = insn_held.addr;
                o_bus_req.acc  = insn_held.acc;
                o_bus_req.w_rb = 1'b0; // fetches only read
            end
            arb_pkg::OWN_DATA: o_bus_req = data_held;
            default: ;
        endcase
    end

    assign o_insn_resp = i_resp && (owner == arb_pkg::OWN_INSN);
    assign o_data_resp = i_resp && (owner == arb_pkg::OWN_DATA);
    assign o_insn_rsp  = (owner == arb_pkg::OWN_INSN) ? i_bus_rsp : '0;
    assign o_data_rsp  = (owner == arb_pkg::OWN_DATA) ? i_bus_rsp : '0;

endmodule

/* design/bus_bridge.sv */
`timescale 1ns/1ps

module bus_bridge (
    input  logic               clk,
    input  logic               rstn,

    // duplexer side
    input  logic               i_d_req,
    input  bus_pkg::data_req_t i_d_bus_req,
    output logic               o_d_resp,
    output bus_pkg::bus_rsp_t  o_d_bus_rsp,

    // memory side
    output logic               o_p_req,
    output bus_pkg::data_req_t o_p_bus_req,
    input  logic               i_p_resp,
    input  bus_pkg::bus_rsp_t  i_p_bus_rsp
);

    // strobes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_p_req  <= 1'b0;
            o_d_resp <= 1'b0;
        end else begin
            o_p_req  <= i_d_req;
            o_d_resp <= i_p_resp;
        end
    end

    always_ff @(posedge clk) begin
        o_p_bus_req <= i_d_bus_req;
        o_d_bus_rsp <= i_p_bus_rsp;
    end

endmodule

/* design/sram_slave.sv */
`timescale 1ns/1ps
`include "bus_defines.svh"

module sram_slave (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_req,
    input  bus_pkg::data_req_t  i_bus_req,
    output logic                o_resp,
    output bus_pkg::bus_rsp_t   o_bus_rsp
);
    localparam int LANES  = `BUS_WIDTH / 8;
    localparam int LANE_W = $clog2(LANES);
    localparam int IDX_W  = $clog2(`MEM_WORDS);
    localparam logic [`BUS_WIDTH-1:0] BYTE_MASK = 'hff;
    localparam logic [`BUS_WIDTH-1:0] HALF_MASK = 'hffff;

    logic [`BUS_WIDTH-1:0] mem [`MEM_WORDS];
    bus_pkg::data_req_t    req_q;
    logic                  busy;
    logic                  done;
    logic [LANE_W-1:0]     lane;
    logic [IDX_W-1:0]      idx;
    logic                  in_range;
    logic                  misaligned;
    logic                  fault;
    logic [LANES-1:0]      be;
    logic [`BUS_WIDTH-1:0] rd_mask;
    logic [`BUS_WIDTH-1:0] wdata_sh;
    logic [`BUS_WIDTH-1:0] rd_sh;

    wait_timer u_timer (
        .clk    (clk),
        .rstn   (rstn),
        .i_start(i_req),
        .o_busy (busy),
        .o_done (done)
    );

    always_ff @(posedge clk) begin
        if (i_req && !busy)
            req_q <= i_bus_req; // keep the access in flight intact
    end

    assign lane     = req_q.addr[LANE_W-1:0];
    assign idx      = req_q.addr[IDX_W+LANE_W-1:LANE_W];
    assign in_range = req_q.addr[`XLEN-1:LANE_W] < `MEM_WORDS;

    always_comb begin
        case (req_q.acc)
            bus_pkg::ACC_BYTE: begin
                misaligned = 1'b0;
                be         = LANES'(1) << lane;
                rd_mask    = BYTE_MASK;
            end
            bus_pkg::ACC_HALF: begin
                misaligned = lane[0];
                be         = LANES'(3) << lane;
                rd_mask    = HALF_MASK;
            end
            bus_pkg::ACC_WORD: begin
                misaligned = lane != '0;
                be         = '1;
                rd_mask    = '1;
            end
            default: begin
                misaligned = 1'b1; // unknown size
                be         = '0;
                rd_mask    = '0;
            end
        endcase
    end

    assign fault    = misaligned | ~in_range;
    assign wdata_sh = req_q.wdata << {lane, 3'b000};
    assign rd_sh    = mem[idx] >> {lane, 3'b000};

    always_ff @(posedge clk) begin
        if (done && req_q.w_rb && !fault) begin
            for (int b = 0; b < LANES; b++) begin
                if (be[b])
                    mem[idx][8*b +: 8] <= wdata_sh[8*b +: 8];
            end
        end
    end

    // writes and faults answer zero data
    always_ff @(posedge clk) begin
        if (done) begin
            o_bus_rsp.fault <= fault;
            o_bus_rsp.rdata <= (fault || req_q.w_rb) ? '0 : (rd_sh & rd_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            o_resp <= 1'b0;
        else
            o_resp <= done;
    end

    a_fixed_latency: assert property (@(posedge clk) disable iff (!rstn)
        i_req |-> ##(`MEM_WAIT + 1) o_resp)
        else $error("memory resp not after MEM_WAIT + 1 cycles");

endmodule

/* design/wait_timer.sv */
`timescale 1ns/1ps
`include "bus_defines.svh"

module wait_timer (
    input  logic clk,
    input  logic rstn,
    input  logic i_start,
    output logic o_busy,
    output logic o_done
);
    localparam int CNT_W = $clog2(`MEM_WAIT + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rstn)
            count_q <= '0;
        else if (i_start)
            count_q <= CNT_W'(`MEM_WAIT);
        else if (count_q != '0)
            count_q <= count_q - 1'b1;
    end

    assign o_busy = count_q != '0;
    assign o_done = count_q == CNT_W'(1); // last wait cycle

    a_no_restart: assert property (@(posedge clk) disable iff (!rstn)
        i_start |-> !o_busy)
        else $error("timer restarted while busy");

endmodule

/* design/bus_owner_fsm.sv */
`timescale 1ns/1ps

module bus_owner_fsm (
    input  logic            clk,
    input  logic            rstn,
    input  logic            i_insn_req,
    input  logic            i_data_req,
    input  logic            i_insn_pending,
    input  logic            i_data_pending,
    input  logic            i_resp,
    output arb_pkg::owner_e o_owner,
    output arb_pkg::owner_e o_next_owner,
    output logic            o_req
);
    arb_pkg::owner_e owner_q;
    arb_pkg::owner_e next_owner;
    logic            data_wants;
    logic            insn_wants;

    always_ff @(posedge clk) begin
        if (!rstn)
            owner_q <= arb_pkg::OWN_NONE;
        else
            owner_q <= next_owner;
    end

    // a request now or one that waited behind the other port
    assign data_wants = i_data_req | i_data_pending;
    assign insn_wants = i_insn_req | i_insn_pending;

    always_comb begin
        next_owner = owner_q;
        o_req      = 1'b0;
        case (owner_q)
            arb_pkg::OWN_INSN: begin
                if (i_resp) begin
                    // hand over to data if it waits
                    if (data_wants)
                        next_owner = arb_pkg::OWN_DATA;
                    else if (i_insn_req)
                        next_owner = arb_pkg::OWN_INSN;
                    else
                        next_owner = arb_pkg::OWN_NONE;
                    o_req = data_wants | i_insn_req;
                end
            end
            arb_pkg::OWN_DATA: begin
                if (i_resp) begin
                    if (insn_wants)
                        next_owner = arb_pkg::OWN_INSN;
                    else if (i_data_req)
                        next_owner = arb_pkg::OWN_DATA;
                    else
                        next_owner = arb_pkg::OWN_NONE;
                    o_req = insn_wants | i_data_req;
                end
            end
            default: begin
                if (i_data_req)
                    next_owner = arb_pkg::OWN_DATA; // data first on a tie
                else if (i_insn_req)
                    next_owner = arb_pkg::OWN_INSN;
                else
                    next_owner = arb_pkg::OWN_NONE;
                o_req = i_data_req | i_insn_req;
            end
        endcase
    end

    assign o_owner      = owner_q;
    assign o_next_owner = next_owner;

    a_resp_has_owner: assert property (@(posedge clk) disable iff (!rstn)
        i_resp |-> owner_q != arb_pkg::OWN_NONE)
        else $error("bus resp with no owner");

endmodule

/* design/req_hold_reg.sv */
`timescale 1ns/1ps

module req_hold_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     i_req,
    input  payload_t i_payload,
    output payload_t o_payload,
    input  logic     i_resp,
    output logic     o_pending
);
    payload_t held_q;

    always_ff @(posedge clk) begin
        if (i_req)
            held_q <= i_payload;
    end

    // access ongoing until own resp
    always_ff @(posedge clk) begin
        if (!rstn)
            o_pending <= 1'b0;
        else if (i_req)
            o_pending <= 1'b1;
        else if (i_resp)
            o_pending <= 1'b0;
    end

    assign o_payload = i_req ? i_payload : held_q; // bypass in the req cycle

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        i_req |-> !o_pending)
        else $error("new req while previous access still pending");

endmodule

/* design/arb_pkg.sv */
package arb_pkg;

    // which port holds the memory bus
    typedef enum logic [1:0] {
        OWN_NONE = 2'd0,
        OWN_INSN = 2'd1,
        OWN_DATA = 2'd2
    } owner_e;

endpackage

/* design/bus_pkg.sv */
`include "bus_defines.svh"

package bus_pkg;

    // access size
    typedef enum logic [$clog2(`BUS_ACC_CNT)-1:0] {
        ACC_BYTE = 0,
        ACC_HALF = 1,
        ACC_WORD = 2
    } acc_e;

    typedef struct packed {
        logic [`XLEN-1:0] addr; // byte addr
        acc_e             acc;
    } insn_req_t;

    // also the memory bus request
    typedef struct packed {
        logic [`XLEN-1:0]      addr; // byte addr
        logic                  w_rb; // 1 = write
        acc_e                  acc;
        logic [`BUS_WIDTH-1:0] wdata;
    } data_req_t;

    typedef struct packed {
        logic [`BUS_WIDTH-1:0] rdata; // right-aligned, zero-extended
        logic                  fault;
    } bus_rsp_t;

endpackage

/* include/bus_defines.svh */
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// byte address width
`define XLEN 32

// data bus width
`define BUS_WIDTH 32

// byte, halfword, word
`define BUS_ACC_CNT 3

// memory depth in words
`define MEM_WORDS 256

// wait cycles before the memory answers
`define MEM_WAIT 2

`endif
